// ==== hdl/core_control.sv ====
`timescale 1ns/100ps

module core_control #(
    parameter int address_width = 16
) (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic                              run,
    input  rv_isa_pkg::decoded_inst_t         dec,
    input  logic [rv_isa_pkg::word_width-1:0] alu_result,
    input  logic                              branch_taken,
    input  logic [rv_isa_pkg::word_width-1:0] rs2_value,
    input  logic [rv_isa_pkg::word_width-1:0] inst_ram_read_result,
    input  logic [rv_isa_pkg::word_width-1:0] data_ram_read_result,
    output logic [rv_isa_pkg::word_width-1:0] inst_word,
    output logic [rv_isa_pkg::word_width-1:0] pc,
    output core_pkg::reg_write_t              wb,
    output logic                              halted,
    output logic [address_width-1:0]          inst_ram_address,
    output logic [address_width-1:0]          data_ram_address,
    output logic [rv_isa_pkg::word_width-1:0] data_ram_write_data,
    output logic                              data_ram_write
);

    core_pkg::core_state_t             state;
    logic [rv_isa_pkg::word_width-1:0] pc_plus4;
    logic                              is_jump;
    logic                              has_rd;

    assign pc_plus4 = pc + rv_isa_pkg::word_width'(4);
    assign is_jump  = (dec.opcode == rv_isa_pkg::op_jal) ||
                      (dec.opcode == rv_isa_pkg::op_jalr);

    // opcodes that write rd
    always_comb begin
        case (dec.opcode)
            rv_isa_pkg::op_imm,
            rv_isa_pkg::op_reg,
            rv_isa_pkg::op_lui,
            rv_isa_pkg::op_jal,
            rv_isa_pkg::op_jalr,
            rv_isa_pkg::op_load: has_rd = 1'b1;
            default:             has_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= core_pkg::st_init;
            pc             <= '0;
            halted         <= 1'b0;
            data_ram_write <= 1'b0;
            wb.enable      <= 1'b0;
        end else if (run) begin
            case (state)
                core_pkg::st_init: begin
                    pc    <= '0;
                    state <= core_pkg::st_fetch;
                end
                core_pkg::st_fetch: begin
                    // last retire's write lands on this edge
                    wb.enable        <= 1'b0;
                    inst_ram_address <= pc[address_width-1:0];
                    state            <= core_pkg::st_fetch2;
                end
                core_pkg::st_fetch2: begin
                    state <= core_pkg::st_decode;
                end
                core_pkg::st_decode: begin
                    inst_word <= inst_ram_read_result;
                    state     <= core_pkg::st_execute;
                end
                core_pkg::st_execute: begin
                    if (dec.is_halt) begin
                        halted <= 1'b1;
                        state  <= core_pkg::st_halted;
                    end else if (dec.opcode == rv_isa_pkg::op_load) begin
                        state <= core_pkg::st_load;
                    end else if (dec.opcode == rv_isa_pkg::op_store) begin
                        state <= core_pkg::st_store;
                    end else begin
                        state <= core_pkg::st_retire;
                    end
                end
                core_pkg::st_load: begin
                    data_ram_address <= alu_result[address_width-1:0];
                    state            <= core_pkg::st_load2;
                end
                core_pkg::st_load2: begin
                    // RAM output settles here, sampled in retire
                    state <= core_pkg::st_retire;
                end
                core_pkg::st_store: begin
                    data_ram_address    <= alu_result[address_width-1:0];
                    data_ram_write_data <= rs2_value;
                    data_ram_write      <= 1'b1;
                    state               <= core_pkg::st_retire;
                end
                core_pkg::st_retire: begin
                    data_ram_write <= 1'b0;
                    wb.enable      <= has_rd && (dec.rd != '0);
                    wb.addr        <= dec.rd;
                    if (is_jump) begin
                        wb.data <= pc_plus4;
                    end else if (dec.opcode == rv_isa_pkg::op_load) begin
                        wb.data <= data_ram_read_result;
                    end else begin
                        wb.data <= alu_result;
                    end
                    // jalr targets may be odd, bit 0 is dropped
                    if (is_jump) begin
                        pc <= {alu_result[rv_isa_pkg::word_width-1:1], 1'b0};
                    end else if (branch_taken) begin
                        pc <= alu_result;
                    end else begin
                        pc <= pc_plus4;
                    end
                    state <= core_pkg::st_fetch;
                end
                core_pkg::st_halted: begin
                    state <= core_pkg::st_halted;
                end
                default: begin
                    state <= core_pkg::st_init;
                end
            endcase
        end
    end

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

    // one instruction walks fetch, fetch2, decode, execute, then retire
    // loads and stores take a detour between execute and retire
    typedef enum logic [3:0] {
        st_init,
        st_fetch,
        st_fetch2,
        st_decode,
        st_execute,
        st_load,
        st_load2,
        st_store,
        st_retire,
        st_halted
    } core_state_t;

    // register write-back, applied one edge after it is registered
    typedef struct packed {
        logic                                  enable;
        logic [rv_isa_pkg::reg_addr_width-1:0] addr;
        logic [rv_isa_pkg::word_width-1:0]     data;
    } reg_write_t;

endpackage

// ==== hdl/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit (
    input  rv_isa_pkg::decoded_inst_t         dec,
    input  logic [rv_isa_pkg::word_width-1:0] rs1_value,
    input  logic [rv_isa_pkg::word_width-1:0] rs2_value,
    input  logic [rv_isa_pkg::word_width-1:0] pc,
    output logic [rv_isa_pkg::word_width-1:0] alu_result,
    output logic                              branch_taken
);

    logic [rv_isa_pkg::word_width-1:0] op_a;
    logic [rv_isa_pkg::word_width-1:0] op_b;
    logic                              is_shift;
    logic                              condition;

    assign is_shift = (dec.alu_op == rv_isa_pkg::alu_sll) ||
                      (dec.alu_op == rv_isa_pkg::alu_srl) ||
                      (dec.alu_op == rv_isa_pkg::alu_sra);

    // pc based targets for jal and branches, lui adds its immediate to zero
    always_comb begin
        case (dec.opcode)
            rv_isa_pkg::op_jal,
            rv_isa_pkg::op_branch: op_a = pc;
            rv_isa_pkg::op_lui:    op_a = '0;
            default:               op_a = rs1_value;
        endcase
    end

    // shift amounts are only the low five bits
    always_comb begin
        if (dec.opcode == rv_isa_pkg::op_reg) begin
            op_b = is_shift ? {27'b0, rs2_value[4:0]} : rs2_value;
        end else begin
            op_b = is_shift ? {27'b0, dec.imm[4:0]} : dec.imm;
        end
    end

    always_comb begin
        alu_result = '0;
        case (dec.alu_op)
            rv_isa_pkg::alu_add:  alu_result = op_a + op_b;
            rv_isa_pkg::alu_sub:  alu_result = op_a - op_b;
            rv_isa_pkg::alu_sll:  alu_result = op_a << op_b;
            rv_isa_pkg::alu_srl:  alu_result = op_a >> op_b;
            rv_isa_pkg::alu_sra:  alu_result = $signed(op_a) >>> op_b;
            rv_isa_pkg::alu_xor:  alu_result = op_a ^ op_b;
            rv_isa_pkg::alu_and:  alu_result = op_a & op_b;
            rv_isa_pkg::alu_or:   alu_result = op_a | op_b;
            rv_isa_pkg::alu_slt:  alu_result[0] = $signed(op_a) < $signed(op_b);
            rv_isa_pkg::alu_sltu: alu_result[0] = op_a < op_b;
            default:              alu_result = '0;
        endcase
    end

    // branch compare works on the registers, the ALU builds the target
    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::f3_beq:  condition = (rs1_value == rs2_value);
            rv_isa_pkg::f3_bne:  condition = (rs1_value != rs2_value);
            rv_isa_pkg::f3_blt:  condition = $signed(rs1_value) < $signed(rs2_value);
            rv_isa_pkg::f3_bge:  condition = $signed(rs1_value) >= $signed(rs2_value);
            rv_isa_pkg::f3_bltu: condition = rs1_value < rs2_value;
            rv_isa_pkg::f3_bgeu: condition = rs1_value >= rs2_value;
            default:             condition = 1'b0;
        endcase
    end

    assign branch_taken = (dec.opcode == rv_isa_pkg::op_branch) && condition;

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  logic [rv_isa_pkg::word_width-1:0] inst_word,
    output rv_isa_pkg::decoded_inst_t         dec
);

    logic [rv_isa_pkg::word_width-1:0] imm_i;
    logic [rv_isa_pkg::word_width-1:0] imm_s;
    logic [rv_isa_pkg::word_width-1:0] imm_b;
    logic [rv_isa_pkg::word_width-1:0] imm_u;
    logic [rv_isa_pkg::word_width-1:0] imm_j;
    rv_isa_pkg::opcode_t               opcode;
    rv_isa_pkg::alu_op_t               int_op;
    logic                              alt;

    assign opcode = rv_isa_pkg::opcode_t'(inst_word[6:0]);
    // bit 30 selects sub and sra
    assign alt = inst_word[30];

    // immediates for every format, sign bit always in bit 31
    assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
    assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
    assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                    inst_word[30:25], inst_word[11:8], 1'b0};
    assign imm_u = {inst_word[31:12], 12'b0};
    assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                    inst_word[20], inst_word[30:21], 1'b0};

    // funct3 to ALU op, sub only exists in the register form
    always_comb begin
        case (inst_word[14:12])
            rv_isa_pkg::f3_add:  int_op = (opcode == rv_isa_pkg::op_reg && alt) ?
                                          rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
            rv_isa_pkg::f3_sll:  int_op = rv_isa_pkg::alu_sll;
            rv_isa_pkg::f3_slt:  int_op = rv_isa_pkg::alu_slt;
            rv_isa_pkg::f3_sltu: int_op = rv_isa_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:  int_op = rv_isa_pkg::alu_xor;
            rv_isa_pkg::f3_srl:  int_op = alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
            rv_isa_pkg::f3_or:   int_op = rv_isa_pkg::alu_or;
            default:             int_op = rv_isa_pkg::alu_and;
        endcase
    end

    always_comb begin
        dec.opcode  = opcode;
        dec.funct3  = inst_word[14:12];
        dec.rd      = inst_word[11:7];
        dec.rs1     = inst_word[19:15];
        dec.rs2     = inst_word[24:20];
        dec.imm     = imm_i;
        dec.alu_op  = rv_isa_pkg::alu_add;
        dec.is_halt = 1'b0;
        case (opcode)
            rv_isa_pkg::op_imm,
            rv_isa_pkg::op_reg:    dec.alu_op = int_op;
            rv_isa_pkg::op_store:  dec.imm = imm_s;
            rv_isa_pkg::op_branch: dec.imm = imm_b;
            rv_isa_pkg::op_lui:    dec.imm = imm_u;
            rv_isa_pkg::op_jal:    dec.imm = imm_j;
            rv_isa_pkg::op_jalr,
            rv_isa_pkg::op_load:   dec.imm = imm_i;
            rv_isa_pkg::op_system: begin
                dec.alu_op  = rv_isa_pkg::alu_none;
                dec.is_halt = (imm_i == rv_isa_pkg::halt_imm);
            end
            // anything else retires as a no-op
            default:               dec.alu_op = rv_isa_pkg::alu_none;
        endcase
    end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic [rv_isa_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [rv_isa_pkg::reg_addr_width-1:0] rs2_addr,
    output logic [rv_isa_pkg::word_width-1:0]     rs1_value,
    output logic [rv_isa_pkg::word_width-1:0]     rs2_value,
    input  core_pkg::reg_write_t                  wb
);

    // x0 has no storage
    logic [rv_isa_pkg::word_width-1:0] regs [1:31];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            // every program starts from a zeroed bank
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int word_width = 32;
    localparam int reg_addr_width = 5;

    // major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_xor,
        alu_and,
        alu_or,
        alu_slt,
        alu_sltu,
        alu_none
    } alu_op_t;

    // branch conditions in funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // integer ALU ops in funct3, shared by the imm and reg forms
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // system immediate of ebreak
    localparam logic [word_width-1:0] halt_imm = 1;

    typedef struct packed {
        opcode_t                   opcode;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [word_width-1:0]     imm;
        alu_op_t                   alu_op;
        logic                      is_halt;
    } decoded_inst_t;

endpackage

// ==== hdl/shader_core.sv ====
`timescale 1ns/100ps

module shader_core #(
    parameter int address_width = 16
) (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic                              run,
    input  logic [rv_isa_pkg::word_width-1:0] inst_ram_read_result,
    input  logic [rv_isa_pkg::word_width-1:0] data_ram_read_result,
    output logic                              halted,
    output logic [address_width-1:0]          inst_ram_address,
    output logic [address_width-1:0]          data_ram_address,
    output logic [rv_isa_pkg::word_width-1:0] data_ram_write_data,
    output logic                              data_ram_write
);

    logic [rv_isa_pkg::word_width-1:0] inst_word;
    logic [rv_isa_pkg::word_width-1:0] pc;
    logic [rv_isa_pkg::word_width-1:0] rs1_value;
    logic [rv_isa_pkg::word_width-1:0] rs2_value;
    logic [rv_isa_pkg::word_width-1:0] alu_result;
    logic                              branch_taken;
    rv_isa_pkg::decoded_inst_t         dec;
    core_pkg::reg_write_t              wb;

    core_control #(
        .address_width(address_width)
    ) control_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .run                 (run),
        .dec                 (dec),
        .alu_result          (alu_result),
        .branch_taken        (branch_taken),
        .rs2_value           (rs2_value),
        .inst_ram_read_result(inst_ram_read_result),
        .data_ram_read_result(data_ram_read_result),
        .inst_word           (inst_word),
        .pc                  (pc),
        .wb                  (wb),
        .halted              (halted),
        .inst_ram_address    (inst_ram_address),
        .data_ram_address    (data_ram_address),
        .data_ram_write_data (data_ram_write_data),
        .data_ram_write      (data_ram_write)
    );

    inst_decoder decoder_i (
        .inst_word(inst_word),
        .dec      (dec)
    );

    register_file regs_i (
        .clock    (clock),
        .reset_n  (reset_n),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .wb       (wb)
    );

    execute_unit exec_i (
        .dec         (dec),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .pc          (pc),
        .alu_result  (alu_result),
        .branch_taken(branch_taken)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f shader_core.f \
    --top-module shader_core_tb -Mdir obj_dir

./obj_dir/Vshader_core_tb | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== shader_core.f ====
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/inst_decoder.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/core_control.sv
hdl/shader_core.sv
sim/clock_gen.sv
sim/shader_core_asserts.sv
sim/shader_core_tb.sv

// ==== sim/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 16
) (
    input  logic reset_request,
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // power-on reset, then one more reset per request
    initial begin
        reset_n = 1'b0;
        forever begin
            repeat (reset_cycles) @(negedge clock);
            reset_n = 1'b1;
            wait (reset_request);
            @(negedge clock);
            reset_n = 1'b0;
        end
    end

endmodule

// ==== sim/shader_core_asserts.sv ====
`timescale 1ns/100ps

module shader_core_asserts (
    input logic clock,
    input logic reset_n,
    input logic run,
    input logic halted,
    input logic data_ram_write
);

    // a store strobe lasts one running cycle
    assert property (@(posedge clock) disable iff (!reset_n)
        (data_ram_write && run) |=> !data_ram_write)
        else $error("data_ram_write stayed high for two running cycles");

    // halted is sticky until reset
    assert property (@(posedge clock) disable iff (!reset_n)
        halted |=> halted)
        else $error("halted fell while reset_n was high");

    assert property (@(posedge clock) disable iff (!reset_n)
        !(halted && data_ram_write))
        else $error("data_ram_write high while halted");

    assert property (@(posedge clock)
        !reset_n |=> (!halted && !data_ram_write))
        else $error("halted or data_ram_write not cleared by reset");

endmodule

bind core_control shader_core_asserts asserts_i (
    .clock         (clock),
    .reset_n       (reset_n),
    .run           (run),
    .halted        (halted),
    .data_ram_write(data_ram_write)
);

// ==== sim/shader_core_tb.sv ====
`timescale 1ns/100ps

module shader_core_tb;

    localparam int address_width = 16;
    localparam int mem_words     = 2 ** (address_width - 2);
    localparam int max_tests     = 16;
    localparam int max_words     = 64;
    localparam int max_stores    = 16;

    logic                     clock;
    logic                     reset_n;
    logic                     reset_request;
    logic                     run;
    logic [31:0]              inst_ram_read_result;
    logic [31:0]              data_ram_read_result;
    logic                     halted;
    logic [address_width-1:0] inst_ram_address;
    logic [address_width-1:0] data_ram_address;
    logic [31:0]              data_ram_write_data;
    logic                     data_ram_write;

    logic [31:0]  imem [mem_words];
    logic [31:0]  dmem [mem_words];
    logic [31:0]  seen_addr [$];
    logic [31:0]  seen_data [$];
    logic         write_prev;
    logic         store_after_halt;
    logic [31:0]  lcg_state;
    int           errors;
    int           failed_tests;

    // test records from the data file
    logic [255:0] test_name [max_tests];
    int           test_limit [max_tests];
    bit           test_random [max_tests];
    int           prog_len [max_tests];
    logic [31:0]  prog_words [max_tests][max_words];
    int           exp_count [max_tests];
    logic [31:0]  exp_addr [max_tests][max_stores];
    logic [31:0]  exp_data [max_tests][max_stores];
    int           num_tests;
    int           watchdog_cycles;
    bit           watchdog_armed;

    clock_gen clock_i (
        .reset_request(reset_request),
        .clock        (clock),
        .reset_n      (reset_n)
    );

    shader_core #(
        .address_width(address_width)
    ) dut_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .run                 (run),
        .inst_ram_read_result(inst_ram_read_result),
        .data_ram_read_result(data_ram_read_result),
        .halted              (halted),
        .inst_ram_address    (inst_ram_address),
        .data_ram_address    (data_ram_address),
        .data_ram_write_data (data_ram_write_data),
        .data_ram_write      (data_ram_write)
    );

    // registered RAM reads, one cycle of latency
    always @(posedge clock) begin
        inst_ram_read_result <= imem[inst_ram_address[address_width-1:2]];
        data_ram_read_result <= dmem[data_ram_address[address_width-1:2]];
    end

    always @(posedge clock) begin
        if (data_ram_write) begin
            dmem[data_ram_address[address_width-1:2]] <= data_ram_write_data;
        end
    end

    // one log entry per store strobe, even if run stalls it
    always @(posedge clock) begin
        if (!reset_n) begin
            write_prev <= 1'b0;
        end else begin
            write_prev <= data_ram_write;
            if (data_ram_write && !write_prev) begin
                seen_addr.push_back({16'b0, data_ram_address});
                seen_data.push_back(data_ram_write_data);
                if (halted) begin
                    store_after_halt = 1'b1;
                end
            end
        end
    end

    function automatic logic [31:0] next_lcg(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        wait (watchdog_armed);
        #(watchdog_cycles * 100);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic read_tests();
        int           fd;
        int           code;
        int           n;
        int           t;
        logic [255:0] tok;
        logic [255:0] mode;
        logic [1023:0] rest;
        logic [31:0]  a;
        logic [31:0]  d;
        num_tests = 0;
        t = 0;
        fd = $fopen("sim/shader_core_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/shader_core_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "test") begin
                t = num_tests;
                num_tests++;
                code = $fscanf(fd, "%s %d %s", test_name[t], test_limit[t], mode);
                test_random[t] = (mode == "random");
                prog_len[t] = 0;
                exp_count[t] = 0;
            end else if (tok == "prog") begin
                code = $fscanf(fd, "%d", n);
                prog_len[t] = n;
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", prog_words[t][i]);
                end
            end else if (tok == "store") begin
                code = $fscanf(fd, "%d", n);
                exp_count[t] = n;
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h %h", a, d);
                    exp_addr[t][i] = a;
                    exp_data[t][i] = d;
                end
            end else begin
                $display("unknown record %0s in test file", tok);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        int cycles;
        int real_cycles;
        int errors_before;
        errors_before = errors;
        @(negedge clock);
        run = 1'b0;
        reset_request = 1'b1;
        wait (!reset_n);
        reset_request = 1'b0;
        // memories are loaded while the core sits in reset
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = {6'd0, i[13:0], 12'h037};
            dmem[i] <= 32'hc0de0000 | i;
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i] = prog_words[t][i];
        end
        seen_addr.delete();
        seen_data.delete();
        store_after_halt = 1'b0;
        wait (reset_n);
        if (halted !== 1'b0) begin
            $display("FAIL %0t halted got %b expected 0", $time, halted);
            errors++;
        end
        cycles = 0;
        real_cycles = 0;
        while (!halted && cycles < test_limit[t] && real_cycles < 4 * test_limit[t]) begin
            if (test_random[t]) begin
                lcg_state = next_lcg(lcg_state);
                run = lcg_state[16];
            end else begin
                run = 1'b1;
            end
            if (run) begin
                cycles++;
            end
            real_cycles++;
            @(negedge clock);
        end
        if (!halted) begin
            $display("test %0s: halted did not rise within %0d cycles",
                     test_name[t], test_limit[t]);
            errors++;
        end
        // keep the core running a little to catch stray stores
        run = 1'b1;
        repeat (3) @(negedge clock);
        run = 1'b0;
        if (store_after_halt) begin
            $display("test %0s: a store followed halted", test_name[t]);
            errors++;
        end
        if (seen_addr.size() != exp_count[t]) begin
            $display("test %0s: expected %0d stores but saw %0d",
                     test_name[t], exp_count[t], seen_addr.size());
            errors++;
        end
        for (int i = 0; i < exp_count[t] && i < seen_addr.size(); i++) begin
            if (seen_addr[i] !== exp_addr[t][i]) begin
                $display("FAIL %0t data_ram_address got %h expected %h",
                         $time, seen_addr[i], exp_addr[t][i]);
                errors++;
            end
            if (seen_data[i] !== exp_data[t][i]) begin
                $display("FAIL %0t data_ram_write_data got %h expected %h",
                         $time, seen_data[i], exp_data[t][i]);
                errors++;
            end
        end
        if (errors == errors_before) begin
            $display("test %0s (%0s): ok, %0d stores", test_name[t],
                     test_random[t] ? "random" : "steady", seen_addr.size());
        end else begin
            $display("test %0s (%0s): %0d errors", test_name[t],
                     test_random[t] ? "random" : "steady", errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        int base_tests;
        run = 1'b0;
        reset_request = 1'b0;
        inst_ram_read_result <= '0;
        data_ram_read_result <= '0;
        errors = 0;
        failed_tests = 0;
        lcg_state = 32'd82;
        watchdog_armed = 1'b0;
        read_tests();
        // rerun the multi-path programs with run toggling
        base_tests = num_tests;
        for (int i = 0; i < base_tests; i++) begin
            if (test_name[i] == "branch" || test_name[i] == "load_store") begin
                test_name[num_tests] = test_name[i];
                test_limit[num_tests] = test_limit[i];
                test_random[num_tests] = 1'b1;
                prog_len[num_tests] = prog_len[i];
                prog_words[num_tests] = prog_words[i];
                exp_count[num_tests] = exp_count[i];
                exp_addr[num_tests] = exp_addr[i];
                exp_data[num_tests] = exp_data[i];
                num_tests++;
            end
        end
        watchdog_cycles = 40;
        for (int i = 0; i < num_tests; i++) begin
            watchdog_cycles += test_limit[i] * (test_random[i] ? 4 : 1) + 40;
        end
        watchdog_armed = 1'b1;
        wait (reset_n);
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        $display("summary: %0d tests, %0d failed, %0d errors",
                 num_tests, failed_tests, errors);
        if (errors == 0 && num_tests > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim/shader_core_tests.txt ====
# test <name> <cycle limit> <steady|random>, then prog <count> <hex words>
# then store <count> and <address data> pairs in the order the core writes them
test alu 120 steady
prog 21
10000513 FEC00093 00300113 402081B3 00352023 4020D233 00452223
0040D293 00552423 00209313 00652623 0020A3B3 0020B433 00752823
00852A23 123454B7 67848493 00952C23 0F00C593 00B52E23 00100073
store 8
100 FFFFFFE9 104 FFFFFFFD 108 0FFFFFFE 10C FFFFFFB0
110 00000001 114 00000000 118 12345678 11C FFFFFF1C
test branch 155 steady
prog 36
20000513 FFF00093 00100113 05A00613 00208463 00C52023 00209463 06C52E23 0020C463
06C52E23 0020D463 00C52223 0020E463 00C52423 0020F463 06C52E23 00108463 06C52E23
00109463 00C52623 00114463 00C52823 00115463 06C52E23 00116463 06C52E23 00117463
00C52A23 008002EF 06C52E23 00552C23 08700313 001303E7 06C52E23 00752E23 00100073
store 8
200 0000005A 204 0000005A 208 0000005A 20C 0000005A
210 0000005A 214 0000005A 218 00000074 21C 00000084
test load_store 45 steady
prog 7
30000513 12300093 00152023 00052103 00110113 00252223 00100073
store 2
300 00000123 304 00000124
test zero_reg 25 steady
prog 4
00500013 40000513 00052023 00100073
store 1
400 00000000
